// ==== verilog.f ====
+incdir+hdl
hdl/duck_game_pkg.sv
hdl/duck_bus_pkg.sv
hdl/duck_apb_regs.sv
hdl/duck_shot_capture.sv
hdl/duck_hit_lane.sv
hdl/duck_hit_merge.sv
hdl/duck_game_logic.sv
hdl/duck_hunt_top.sv
testbench/duck_tb_clock.sv
testbench/duck_hunt_tb.sv

// ==== Bender.yml ====
package:
  name: duck_hunt

export_include_dirs:
  - hdl

sources:
  - hdl/duck_game_pkg.sv
  - hdl/duck_bus_pkg.sv
  - hdl/duck_apb_regs.sv
  - hdl/duck_shot_capture.sv
  - hdl/duck_hit_lane.sv
  - hdl/duck_hit_merge.sv
  - hdl/duck_game_logic.sv
  - hdl/duck_hunt_top.sv
  - target: test
    files:
      - testbench/duck_tb_clock.sv
      - testbench/duck_hunt_tb.sv

// ==== testbench/duck_hunt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "duck_hunt_defs.svh"

module duck_hunt_tb import duck_bus_pkg::*, duck_game_pkg::*; ;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_CLICK_IN, OP_CLICK_BOTH, OP_CLICK_OUT,
        OP_RELOAD, OP_WAIT_HUNT, OP_DOUBLE
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [7:0]  addr;
        logic [31:0] data;     // write data
        logic [31:0] exp;      // expected read data
        logic        err;      // expected pslverr
        logic [1:0]  duck;     // target box, also the expected kill index
        logic        kill;     // expected duck_killed
        logic        prompt;   // expected show_reload_char
    } step_t;

    logic                  clk;
    logic                  rst;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;
    logic [11:0]           mouse_xpos;
    logic [11:0]           mouse_ypos;
    logic                  left_mouse;
    logic                  right_mouse;
    logic                  hunt_start;
    logic                  duck_killed;
    logic                  show_reload_char;
    logic [DUCK_IDX_W-1:0] kill_index;

    integer    seed = 32'hcb10_64dc;
    duck_pos_t place [`DUCK_NUM];
    step_t     steps [$];

    duck_tb_clock u_clock (.clk);

    duck_hunt_top u_duck_hunt_top (
        .clk, .rst, .apb_req, .apb_rsp, .mouse_xpos, .mouse_ypos, .left_mouse,
        .right_mouse, .hunt_start, .duck_killed, .show_reload_char, .kill_index
    );

    // ------------------------------------------------------------------------
    // expected values and table entries
    // ------------------------------------------------------------------------
    function automatic logic [31:0] pos_word(duck_pos_t p);
        return {4'h0, p.y, 4'h0, p.x};
    endfunction

    function automatic logic in_box(logic [11:0] x, logic [11:0] y, int d);
        return (int'(x) >= int'(place[d].x)) && (int'(x) <= int'(place[d].x) + `DUCK_WIDTH) &&
               (int'(y) >= int'(place[d].y)) && (int'(y) <= int'(place[d].y) + `DUCK_HEIGHT);
    endfunction

    function automatic step_t write_step(logic [7:0] addr, logic [31:0] data, logic err);
        return '{OP_WRITE, addr, data, 32'h0, err, 2'd0, 1'b0, 1'b0};
    endfunction

    function automatic step_t read_step(logic [7:0] addr, logic [31:0] exp, logic err);
        return '{OP_READ, addr, 32'h0, exp, err, 2'd0, 1'b0, 1'b0};
    endfunction

    // status layout: phase, magazine, reserve, score, prompt, live mask
    function automatic step_t status_step(game_phase_t ph, int mag, int res, int score,
                                          logic prompt, logic [3:0] live);
        logic [31:0] w;
        w = {8'h00, ph, 3'(mag), 7'(res), 7'(score), prompt, live};
        return read_step(`DUCK_REG_STATUS, w, 1'b0);
    endfunction

    function automatic step_t click_step(op_t op, logic [1:0] duck, logic kill, logic prompt);
        return '{op, 8'h00, 32'h0, 32'h0, 1'b0, duck, kill, prompt};
    endfunction

    function automatic step_t bare_step(op_t op);
        return '{op, 8'h00, 32'h0, 32'h0, 1'b0, 2'd0, 1'b0, 1'b0};
    endfunction

    // ------------------------------------------------------------------------
    // checking and failure
    // ------------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic wait_for_hunt(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (hunt_start !== level && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (hunt_start !== level) begin
            $display("Error at %0t ns: hunt_start did not go to %0b in 200 cycles", $time, level);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // bus and mouse drivers
    // ------------------------------------------------------------------------
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data, input logic [31:0] exp,
                                input logic exp_err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);   // access cycle
        check_value("pready", apb_rsp.pready, 1'b1);
        check_value($sformatf("pslverr[0x%02h]", addr), apb_rsp.pslverr, exp_err);
        if (!write && !exp_err) begin
            check_value($sformatf("prdata[0x%02h]", addr), apb_rsp.prdata, exp);
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic pick_point(input op_t op, input int duck,
                              output logic [11:0] x, output logic [11:0] y);
        int   tries;
        logic ok;
        tries = 0;
        ok    = 1'b0;
        while (!ok && tries < 1000) begin
            if (op == OP_CLICK_OUT) begin
                x  = 12'($random(seed));
                y  = 12'($random(seed));
                ok = 1'b1;
                for (int d = 0; d < `DUCK_NUM; d++) begin
                    if (in_box(x, y, d)) ok = 1'b0;
                end
            end else begin
                x  = place[duck].x + 12'($unsigned($random(seed)) % (`DUCK_WIDTH + 1));
                y  = place[duck].y + 12'($unsigned($random(seed)) % (`DUCK_HEIGHT + 1));
                ok = (op == OP_CLICK_IN) || in_box(x, y, duck + 1);   // overlap wanted
            end
            tries++;
        end
        if (!ok) begin
            $display("Error: no pointer position found for duck %0d", duck);
            stop_with_failure();
        end
    endtask

    // result lands three edges after the edge that samples the button
    task automatic fire_shot(input logic [11:0] x, input logic [11:0] y, input logic exp_kill,
                             input logic [1:0] exp_idx, input logic exp_prompt);
        @(posedge clk);
        mouse_xpos <= x;
        mouse_ypos <= y;
        left_mouse <= 1'b1;
        @(posedge clk);   // button sampled
        left_mouse <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("duck_killed", duck_killed, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_value("duck_killed", duck_killed, exp_kill);
        if (exp_kill) begin
            check_value("kill_index", kill_index, exp_idx);
        end
        check_value("show_reload_char", show_reload_char, exp_prompt);
    endtask

    task automatic fire_two_shots();
        logic [11:0] x0;
        logic [11:0] y0;
        logic [11:0] x1;
        logic [11:0] y1;
        pick_point(OP_CLICK_OUT, 0, x0, y0);
        pick_point(OP_CLICK_OUT, 0, x1, y1);
        @(posedge clk);
        mouse_xpos <= x0;
        mouse_ypos <= y0;
        left_mouse <= 1'b1;
        @(posedge clk);
        left_mouse <= 1'b0;
        @(posedge clk);
        mouse_xpos <= x1;
        mouse_ypos <= y1;
        left_mouse <= 1'b1;
        @(posedge clk);
        left_mouse <= 1'b0;
        repeat (4) @(posedge clk);   // second result has reached the controller
    endtask

    task automatic fire_reload();
        @(posedge clk);
        right_mouse <= 1'b1;
        @(posedge clk);
        right_mouse <= 1'b0;
        wait_for_hunt(1'b0);   // reload delay under way
    endtask

    task automatic run_step(input step_t s);
        logic [11:0] x;
        logic [11:0] y;
        case (s.op)
            OP_WRITE:     apb_transfer(1'b1, s.addr, s.data, 32'h0, s.err);
            OP_READ:      apb_transfer(1'b0, s.addr, 32'h0, s.exp, s.err);
            OP_RELOAD:    fire_reload();
            OP_WAIT_HUNT: wait_for_hunt(1'b1);
            OP_DOUBLE:    fire_two_shots();
            default: begin
                pick_point(s.op, s.duck, x, y);
                fire_shot(x, y, s.kill, s.duck, s.prompt);
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // step table and main sequence
    // ------------------------------------------------------------------------
    initial begin
        place[0] = '{x: 12'd100, y: 12'd100};
        place[1] = '{x: 12'd150, y: 12'd120};   // overlaps duck 0
        place[2] = '{x: 12'd400, y: 12'd300};
        place[3] = '{x: 12'd700, y: 12'd500};

        // reset defaults
        steps.push_back(read_step(`DUCK_REG_CTRL, 32'h0, 1'b0));
        steps.push_back(read_step(`DUCK_REG_COUNTDOWN, `DUCK_COUNTDOWN_DEF, 1'b0));
        steps.push_back(read_step(`DUCK_REG_DEATH, `DUCK_DEATH_DEF, 1'b0));
        steps.push_back(read_step(`DUCK_REG_RELOAD, `DUCK_RELOAD_DEF, 1'b0));
        steps.push_back(read_step(`DUCK_REG_POS0, 32'h0, 1'b0));
        steps.push_back(read_step(8'h1c, 32'h0, 1'b0));
        steps.push_back(status_step(WAIT_FOR_START, 3, 27, 0, 1'b0, 4'hf));
        // short timers, duck placement
        steps.push_back(write_step(`DUCK_REG_COUNTDOWN, 32'd5, 1'b0));
        steps.push_back(write_step(`DUCK_REG_DEATH, 32'd4, 1'b0));
        steps.push_back(write_step(`DUCK_REG_RELOAD, 32'd3, 1'b0));
        steps.push_back(read_step(`DUCK_REG_COUNTDOWN, 32'd5, 1'b0));
        steps.push_back(read_step(`DUCK_REG_DEATH, 32'd4, 1'b0));
        steps.push_back(read_step(`DUCK_REG_RELOAD, 32'd3, 1'b0));
        for (int i = 0; i < `DUCK_NUM; i++) begin
            steps.push_back(write_step(8'(`DUCK_REG_POS0 + 4 * i), pos_word(place[i]), 1'b0));
        end
        for (int i = 0; i < `DUCK_NUM; i++) begin
            steps.push_back(read_step(8'(`DUCK_REG_POS0 + 4 * i), pos_word(place[i]), 1'b0));
        end
        // bus errors
        steps.push_back(read_step(8'h24, 32'h0, 1'b1));
        steps.push_back(read_step(8'h3c, 32'h0, 1'b1));
        steps.push_back(write_step(`DUCK_REG_STATUS, 32'hffff_ffff, 1'b1));
        steps.push_back(status_step(WAIT_FOR_START, 3, 27, 0, 1'b0, 4'hf));
        // start
        steps.push_back(write_step(`DUCK_REG_CTRL, 32'h1, 1'b0));
        steps.push_back(status_step(DELAY, 3, 27, 0, 1'b0, 4'hf));
        steps.push_back(bare_step(OP_WAIT_HUNT));
        steps.push_back(status_step(HUNTING, 3, 27, 0, 1'b0, 4'hf));
        // hit, then the dead duck is a miss
        steps.push_back(click_step(OP_CLICK_IN, 2'd2, 1'b1, 1'b0));
        steps.push_back(status_step(DELAY, 2, 26, 1, 1'b0, 4'b1011));
        steps.push_back(bare_step(OP_WAIT_HUNT));
        steps.push_back(click_step(OP_CLICK_IN, 2'd2, 1'b0, 1'b0));
        steps.push_back(status_step(HUNTING, 1, 25, 1, 1'b0, 4'b1011));
        // miss, then click on an empty magazine
        steps.push_back(click_step(OP_CLICK_OUT, 2'd0, 1'b0, 1'b0));
        steps.push_back(status_step(HUNTING, 0, 24, 1, 1'b0, 4'b1011));
        steps.push_back(click_step(OP_CLICK_OUT, 2'd0, 1'b0, 1'b1));
        steps.push_back(status_step(HUNTING, 0, 24, 1, 1'b1, 4'b1011));
        // reload takes the spent rounds off the reserve
        steps.push_back(bare_step(OP_RELOAD));
        steps.push_back(bare_step(OP_WAIT_HUNT));
        steps.push_back(status_step(HUNTING, 3, 21, 1, 1'b0, 4'b1011));
        // overlap and back to back shots
        steps.push_back(click_step(OP_CLICK_BOTH, 2'd0, 1'b1, 1'b0));
        steps.push_back(bare_step(OP_WAIT_HUNT));
        steps.push_back(status_step(HUNTING, 2, 20, 2, 1'b0, 4'b1010));
        steps.push_back(bare_step(OP_DOUBLE));
        steps.push_back(status_step(HUNTING, 0, 18, 2, 1'b0, 4'b1010));
        // game stop
        steps.push_back(write_step(`DUCK_REG_CTRL, 32'h0, 1'b0));
        steps.push_back(status_step(WAIT_FOR_START, 0, 18, 2, 1'b0, 4'b1010));

        rst         <= 1'b1;
        apb_req     <= '0;
        mouse_xpos  <= '0;
        mouse_ypos  <= '0;
        left_mouse  <= 1'b0;
        right_mouse <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/duck_tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module duck_tb_clock #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;   // first rising edge half a period in
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== hdl/duck_hunt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "duck_hunt_defs.svh"

module duck_hunt_top import duck_bus_pkg::*, duck_game_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  apb_req_t              apb_req,
    output apb_rsp_t              apb_rsp,
    input  logic [11:0]           mouse_xpos,
    input  logic [11:0]           mouse_ypos,
    input  logic                  left_mouse,
    input  logic                  right_mouse,
    output logic                  hunt_start,
    output logic                  duck_killed,
    output logic                  show_reload_char,
    output logic [DUCK_IDX_W-1:0] kill_index
);

    logic                 game_enable;
    logic [31:0]          countdown_cycles;
    logic [31:0]          death_cycles;
    logic [31:0]          reload_cycles;
    duck_pos_t            duck_pos [`DUCK_NUM];
    game_status_t         status;
    shot_t                shot;
    logic                 reload_req;
    logic [`DUCK_NUM-1:0] lane_hit;
    logic [`DUCK_NUM-1:0] live_mask;
    logic                 hunting;
    hit_t                 hit;

    duck_apb_regs u_regs (
        .clk, .rst, .apb_req, .apb_rsp, .status, .game_enable,
        .countdown_cycles, .death_cycles, .reload_cycles, .duck_pos
    );

    duck_shot_capture u_capture (
        .clk, .rst, .mouse_xpos, .mouse_ypos, .left_mouse, .right_mouse,
        .shot, .reload_req
    );

    // ------------------------------------------------------------------------
    // one hit lane per duck, all fed the same shot
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < `DUCK_NUM; i++) begin : g_lane
        duck_hit_lane u_lane (
            .clk, .rst, .shot,
            .pos         (duck_pos[i]),
            .lane_enable (live_mask[i] && hunting),
            .lane_hit    (lane_hit[i])
        );
    end

    duck_hit_merge u_merge (
        .clk, .rst, .shot_valid(shot.valid), .lane_hit, .hit
    );

    duck_game_logic u_game (
        .clk, .rst, .game_enable, .reload_req, .hit,
        .countdown_cycles, .death_cycles, .reload_cycles,
        .status, .hunting, .live_mask, .hunt_start, .duck_killed, .show_reload_char
    );

    assign kill_index = hit.idx;

endmodule

`default_nettype wire

// ==== hdl/duck_game_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "duck_hunt_defs.svh"

module duck_game_logic import duck_game_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 game_enable,
    input  logic                 reload_req,
    input  hit_t                 hit,
    input  logic [31:0]          countdown_cycles,
    input  logic [31:0]          death_cycles,
    input  logic [31:0]          reload_cycles,
    output game_status_t         status,
    output logic                 hunting,
    output logic [`DUCK_NUM-1:0] live_mask,
    output logic                 hunt_start,
    output logic                 duck_killed,
    output logic                 show_reload_char
);

    game_phase_t          state;
    logic [31:0]          timer;       // phase timer, DELAY only
    logic [2:0]           magazine;
    logic [6:0]           reserve;
    logic [6:0]           score;
    logic [2:0]           spent;
    logic [`DUCK_NUM-1:0] live_left;

    assign spent = 3'(`DUCK_MAG_SIZE) - magazine;

    always_comb begin
        live_left = live_mask;
        live_left[hit.idx] = 1'b0;
    end

    // ------------------------------------------------------------------------
    // phase machine and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= WAIT_FOR_START;
            timer            <= '0;
            magazine         <= 3'(`DUCK_MAG_SIZE);
            reserve          <= 7'(`DUCK_AMMO_TOTAL);
            score            <= '0;
            live_mask        <= '1;
            duck_killed      <= 1'b0;
            show_reload_char <= 1'b0;
        end else begin
            duck_killed <= 1'b0;   // single cycle pulse
            if (!game_enable) begin
                state <= WAIT_FOR_START;
            end else begin
                case (state)
                    WAIT_FOR_START: begin   // fresh game on start
                        state            <= DELAY;
                        timer            <= countdown_cycles;
                        magazine         <= 3'(`DUCK_MAG_SIZE);
                        reserve          <= 7'(`DUCK_AMMO_TOTAL);
                        score            <= '0;
                        live_mask        <= '1;
                        show_reload_char <= 1'b0;
                    end
                    DELAY: begin
                        if (timer == '0) state <= HUNTING;
                        else             timer <= timer - 1'b1;
                    end
                    HUNTING: begin
                        if (reload_req) begin   // reload beats a result landing now
                            state            <= RELOADING;
                            magazine         <= 3'(`DUCK_MAG_SIZE);
                            reserve          <= (reserve >= {4'b0, spent}) ? reserve - spent : '0;
                            show_reload_char <= 1'b0;
                        end else if (hit.valid) begin
                            if (magazine != '0) begin
                                magazine <= magazine - 1'b1;
                                reserve  <= reserve - 1'b1;
                                if (hit.hit) begin
                                    score       <= score + 1'b1;
                                    live_mask   <= (live_left == '0) ? '1 : live_left;
                                    duck_killed <= 1'b1;
                                    state       <= DELAY;
                                    timer       <= death_cycles;
                                end
                            end else begin
                                show_reload_char <= 1'b1;   // click on empty
                            end
                        end
                    end
                    RELOADING: begin
                        state <= DELAY;
                        timer <= reload_cycles;
                    end
                endcase
            end
        end
    end

    assign hunting    = (state == HUNTING);
    assign hunt_start = hunting;

    assign status = '{phase:         state,
                      magazine:      magazine,
                      reserve:       reserve,
                      score:         score,
                      reload_prompt: show_reload_char,
                      live_mask:     live_mask};

endmodule

`default_nettype wire

// ==== hdl/duck_hit_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "duck_hunt_defs.svh"

module duck_hit_merge import duck_game_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 shot_valid,
    input  logic [`DUCK_NUM-1:0] lane_hit,
    output hit_t                 hit
);

    logic                  valid_d;   // lines up with lane_hit
    logic                  hit_valid;
    logic                  hit_any;
    logic [DUCK_IDX_W-1:0] hit_idx;
    logic [DUCK_IDX_W-1:0] low_idx;

    // lowest index wins where boxes overlap
    always_comb begin
        low_idx = '0;
        for (int i = `DUCK_NUM - 1; i >= 0; i--) begin
            if (lane_hit[i]) low_idx = DUCK_IDX_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d   <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            valid_d   <= shot_valid;
            hit_valid <= valid_d;
        end
    end

    // result held until the next shot so the index stays readable
    always_ff @(posedge clk) begin
        if (valid_d) begin
            hit_any <= |lane_hit;
            hit_idx <= low_idx;
        end
    end

    assign hit = '{valid: hit_valid, hit: hit_any, idx: hit_idx};

endmodule

`default_nettype wire

// ==== hdl/duck_hit_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "duck_hunt_defs.svh"

module duck_hit_lane import duck_game_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  shot_t     shot,
    input  duck_pos_t pos,
    input  logic      lane_enable,   // duck alive and game hunting
    output logic      lane_hit
);

    logic in_x;
    logic in_y;

    // box edges are inclusive on both sides
    assign in_x = (shot.x >= pos.x) && (shot.x <= pos.x + `DUCK_WIDTH);
    assign in_y = (shot.y >= pos.y) && (shot.y <= pos.y + `DUCK_HEIGHT);

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_hit <= 1'b0;
        end else begin
            lane_hit <= shot.valid && lane_enable && in_x && in_y;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/duck_shot_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module duck_shot_capture import duck_game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] mouse_xpos,
    input  logic [11:0] mouse_ypos,
    input  logic        left_mouse,
    input  logic        right_mouse,
    output shot_t       shot,
    output logic        reload_req
);

    logic        left_prev;
    logic        right_prev;
    logic        shot_valid;
    logic [11:0] shot_x;
    logic [11:0] shot_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            left_prev  <= 1'b0;
            right_prev <= 1'b0;
            shot_valid <= 1'b0;
            reload_req <= 1'b0;
        end else begin
            left_prev  <= left_mouse;
            right_prev <= right_mouse;
            shot_valid <= left_mouse && !left_prev;     // press only, not hold
            reload_req <= right_mouse && !right_prev;
        end
    end

    // pointer latched every cycle, qualified by shot_valid
    always_ff @(posedge clk) begin
        shot_x <= mouse_xpos;
        shot_y <= mouse_ypos;
    end

    assign shot = '{valid: shot_valid, x: shot_x, y: shot_y};

endmodule

`default_nettype wire

// ==== hdl/duck_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "duck_hunt_defs.svh"

module duck_apb_regs import duck_bus_pkg::*, duck_game_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  apb_req_t     apb_req,
    output apb_rsp_t     apb_rsp,
    input  game_status_t status,
    output logic         game_enable,
    output logic [31:0]  countdown_cycles,
    output logic [31:0]  death_cycles,
    output logic [31:0]  reload_cycles,
    output duck_pos_t    duck_pos [`DUCK_NUM]
);

    logic [7:0]            word_addr;
    logic                  access;
    logic                  is_pos;
    logic                  mapped;
    logic [DUCK_IDX_W-1:0] pos_idx;
    logic [31:0]           rd_data;

    assign word_addr = {apb_req.paddr[7:2], 2'b00};   // byte lanes ignored
    assign access    = apb_req.psel && apb_req.penable;
    assign is_pos    = (word_addr >= `DUCK_REG_POS0) &&
                       (word_addr < `DUCK_REG_POS0 + 4 * `DUCK_NUM);
    assign pos_idx   = DUCK_IDX_W'((word_addr - `DUCK_REG_POS0) >> 2);

    // ------------------------------------------------------------------------
    // writable registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            game_enable      <= 1'b0;
            countdown_cycles <= `DUCK_COUNTDOWN_DEF;
            death_cycles     <= `DUCK_DEATH_DEF;
            reload_cycles    <= `DUCK_RELOAD_DEF;
            for (int i = 0; i < `DUCK_NUM; i++) begin
                duck_pos[i] <= '0;   // parked at origin until placed
            end
        end else if (access && apb_req.pwrite) begin
            if (is_pos) begin
                duck_pos[pos_idx] <= '{x: apb_req.pwdata[11:0], y: apb_req.pwdata[27:16]};
            end else begin
                case (word_addr)
                    `DUCK_REG_CTRL:      game_enable      <= apb_req.pwdata[0];
                    `DUCK_REG_COUNTDOWN: countdown_cycles <= apb_req.pwdata;
                    `DUCK_REG_DEATH:     death_cycles     <= apb_req.pwdata;
                    `DUCK_REG_RELOAD:    reload_cycles    <= apb_req.pwdata;
                    default: ;           // status and holes are not writable
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        mapped  = 1'b1;
        if (is_pos) begin
            rd_data = {4'h0, duck_pos[pos_idx].y, 4'h0, duck_pos[pos_idx].x};
        end else begin
            case (word_addr)
                `DUCK_REG_CTRL:      rd_data = {31'b0, game_enable};
                `DUCK_REG_COUNTDOWN: rd_data = countdown_cycles;
                `DUCK_REG_DEATH:     rd_data = death_cycles;
                `DUCK_REG_RELOAD:    rd_data = reload_cycles;
                `DUCK_REG_STATUS:    rd_data = {8'h00, status};
                default:             mapped  = 1'b0;
            endcase
        end
    end

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;   // every register answers at once
    assign apb_rsp.pslverr = access && (!mapped ||
                             (apb_req.pwrite && word_addr == `DUCK_REG_STATUS));

endmodule

`default_nettype wire

// ==== hdl/duck_bus_pkg.sv ====
`default_nettype none

package duck_bus_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;   // byte offset
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/duck_game_pkg.sv ====
`default_nettype none

`include "duck_hunt_defs.svh"

package duck_game_pkg;

    localparam int DUCK_IDX_W = $clog2(`DUCK_NUM);

    typedef struct packed {
        logic        valid;
        logic [11:0] x;
        logic [11:0] y;
    } shot_t;

    typedef struct packed {
        logic                  valid;
        logic                  hit;   // low means a miss
        logic [DUCK_IDX_W-1:0] idx;   // lowest duck index that was hit
    } hit_t;

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } duck_pos_t;

    typedef enum logic [1:0] {
        WAIT_FOR_START = 2'b00,
        HUNTING        = 2'b01,
        RELOADING      = 2'b10,
        DELAY          = 2'b11
    } game_phase_t;

    typedef struct packed {
        game_phase_t          phase;
        logic [2:0]           magazine;
        logic [6:0]           reserve;
        logic [6:0]           score;
        logic                 reload_prompt;
        logic [`DUCK_NUM-1:0] live_mask;
    } game_status_t;

endpackage

`default_nettype wire

// ==== hdl/duck_hunt_defs.svh ====
`ifndef DUCK_HUNT_DEFS_SVH
`define DUCK_HUNT_DEFS_SVH

`define DUCK_NUM            4    // ducks on screen, one hit lane each
`define DUCK_WIDTH          96   // box size in pixels from the top-left corner
`define DUCK_HEIGHT         60

// phase timer defaults in clock cycles
`define DUCK_COUNTDOWN_DEF  32'd130_000_000
`define DUCK_DEATH_DEF      32'd130_000_000
`define DUCK_RELOAD_DEF     32'd65_000

`define DUCK_MAG_SIZE       3
`define DUCK_AMMO_TOTAL     27   // loaded rounds count against this too

// register byte offsets
`define DUCK_REG_CTRL       8'h00
`define DUCK_REG_COUNTDOWN  8'h04
`define DUCK_REG_DEATH      8'h08
`define DUCK_REG_RELOAD     8'h0C
`define DUCK_REG_POS0       8'h10  // one word per duck
`define DUCK_REG_STATUS     8'h20

`endif
